//--- Makefile
# Verilator flow for the Hough lane project
# Every variable can be overridden on the command line

VERILATOR ?= verilator
TB_TOP ?= hough_tb
RTL_TOP ?= hough_lane_top
FILE_LIST ?= list.f
BUILD_DIR ?= build
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall
FAIL_TEXT ?= Simulation finished: FAIL

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILE_LIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)

# The run fails when the log holds the fail message or the simulator exits with an error
run: build
	./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_TEXT)" $(LOG); then echo "simulation reported failure"; exit 1; fi; \
	if [ $$status -ne 0 ]; then echo "simulator exited with status $$status"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILE_LIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- hdl/hough_accumulator.sv
// Hough accumulator: scans the ROI and votes edge pixels into a rho by theta counter array
`timescale 1ns/1ps
`include "hough_settings.svh"

module hough_accumulator
    import hough_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  logic        start,
    // Samples of the pixel addressed in the previous cycle
    input  pixel_t      hysteresis_data,
    input  pixel_t      mask_data,
    // Address shared by the hysteresis and mask memories
    output pixel_addr_t pixel_addr,
    // Indexed read of the counters for the lane selector
    input  rho_idx_t    read_rho,
    input  theta_idx_t  read_theta,
    output vote_t       read_votes,
    input  logic        select_done,
    output logic        accum_done,
    output logic        busy
);

    localparam coord_x_t LAST_X = coord_x_t'(`IMAGE_WIDTH - 1);
    localparam coord_y_t LAST_Y = coord_y_t'(`IMAGE_HEIGHT - 1);
    localparam coord_y_t FIRST_Y = coord_y_t'(`ROI_TOP_Y);
    // Theta of the first angle in the last unrolled step
    localparam theta_idx_t LAST_THETA_STEP = theta_idx_t'(`THETAS - `THETA_UNROLL);

    accum_state_t state, next_state;

    // Coordinates of the pixel whose samples are on the memory outputs
    coord_x_t x, x_c;
    coord_y_t y, y_c;
    // First angle of the current unrolled step
    theta_idx_t theta, theta_c;

    logic start_accepted;
    logic pixel_pass;
    logic pixel_finished;
    logic last_pixel;
    coord_x_t step_x;
    coord_y_t step_y;

    // Counters, one per rho bin and angle
    vote_t accum [`RHO_RANGE][`THETAS];

    // Trig table built at elaboration from the package functions
    trig_t cos_lut [`THETAS];
    trig_t sin_lut [`THETAS];

    // Bins hit in this cycle, one per unrolled angle
    rho_idx_t vote_rho [`THETA_UNROLL];
    theta_idx_t vote_theta [`THETA_UNROLL];

    // Signed rho of a pixel at an angle, shifted by the offset into a bin index
    // The arithmetic shift floors the fixed point result
    function automatic rho_idx_t rho_index(
        input coord_x_t px,
        input coord_y_t py,
        input trig_t    cos_value,
        input trig_t    sin_value
    );
        logic signed [15:0] dot;
        logic signed [15:0] rho;
        dot = $signed({1'b0, px}) * cos_value + $signed({1'b0, py}) * sin_value;
        rho = dot >>> `TRIG_FRAC;
        return rho_idx_t'(rho + `RHO_OFFSET);
    endfunction

    for (genvar t = 0; t < `THETAS; t++) begin : g_trig
        localparam trig_t COS_VALUE = cos_quantized(theta_idx_t'(t));
        localparam trig_t SIN_VALUE = sin_quantized(theta_idx_t'(t));
        assign cos_lut[t] = COS_VALUE;
        assign sin_lut[t] = SIN_VALUE;
    end

    // Each lane of the unrolled loop owns its own angle
    // The angles differ, so two votes never land in the same counter
    for (genvar u = 0; u < `THETA_UNROLL; u++) begin : g_vote
        assign vote_theta[u] = theta + theta_idx_t'(u);
        assign vote_rho[u] = rho_index(x, y, cos_lut[vote_theta[u]], sin_lut[vote_theta[u]]);
    end

    assign start_accepted = (state == IDLE) && start;
    // Edge pixel that also lies inside the region mask
    assign pixel_pass = (hysteresis_data != '0) && (mask_data == '1);
    assign last_pixel = (x == LAST_X) && (y == LAST_Y);

    // Raster order successor of the current pixel
    assign step_x = (x == LAST_X) ? '0 : x + 1'b1;
    assign step_y = (x == LAST_X) ? y + 1'b1 : y;

    always_comb begin
        next_state = state;
        x_c = x;
        y_c = y;
        theta_c = theta;
        pixel_finished = 1'b0;

        case (state)
            // Jump to the top left corner of the ROI on start
            IDLE: begin
                if (start) begin
                    next_state = ACCUMULATE;
                    x_c = '0;
                    y_c = FIRST_Y;
                end
            end

            // One pixel per cycle unless it has to vote
            ACCUMULATE: begin
                if (pixel_pass) begin
                    next_state = THETA_LOOP;
                    theta_c = '0;
                end else begin
                    pixel_finished = 1'b1;
                end
            end

            // THETA_UNROLL angles per cycle, ending on the last angle
            THETA_LOOP: begin
                if (theta == LAST_THETA_STEP) begin
                    theta_c = '0;
                    pixel_finished = 1'b1;
                end else begin
                    theta_c = theta + theta_idx_t'(`THETA_UNROLL);
                end
            end

            // Counters stay frozen while the selector reads them
            SELECT: begin
                if (select_done) begin
                    next_state = IDLE;
                end
            end

            default: begin
                next_state = IDLE;
            end
        endcase

        // Move to the next pixel or end the scan after the last one
        if (pixel_finished) begin
            if (last_pixel) begin
                next_state = SELECT;
            end else begin
                next_state = ACCUMULATE;
                x_c = step_x;
                y_c = step_y;
            end
        end
    end

    // The address always follows the next coordinates
    // The memory data then matches x and y in the following cycle
    assign pixel_addr = pixel_addr_t'(y_c) * pixel_addr_t'(`IMAGE_WIDTH) + pixel_addr_t'(x_c);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= IDLE;
            x <= '0;
            y <= '0;
            theta <= '0;
            accum_done <= 1'b0;
        end else begin
            state <= next_state;
            x <= x_c;
            y <= y_c;
            theta <= theta_c;
            // Single pulse on the entry into SELECT
            accum_done <= (state != SELECT) && (next_state == SELECT);
        end
    end

    // Counters are cleared on reset and again at every accepted start
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int r = 0; r < `RHO_RANGE; r++) begin
                for (int t = 0; t < `THETAS; t++) begin
                    accum[r][t] <= '0;
                end
            end
        end else if (start_accepted) begin
            for (int r = 0; r < `RHO_RANGE; r++) begin
                for (int t = 0; t < `THETAS; t++) begin
                    accum[r][t] <= '0;
                end
            end
        end else if (state == THETA_LOOP) begin
            for (int u = 0; u < `THETA_UNROLL; u++) begin
                accum[vote_rho[u]][vote_theta[u]] <= accum[vote_rho[u]][vote_theta[u]] + 1'b1;
            end
        end
    end

    // Combinational read for the selector
    assign read_votes = accum[read_rho][read_theta];

    assign busy = (state != IDLE);

endmodule

//--- hdl/hough_lane_top.sv
// Hough lane top level: image memories, vote accumulator and lane selector
`timescale 1ns/1ps

module hough_lane_top
    import hough_pkg::*;
(
    input  logic         clock,
    input  logic         reset,
    input  logic         start,
    // Loads one pixel of both images per cycle while idle
    input  pixel_write_t pixel_write,
    output lane_pair_t   lanes,
    output logic         done,
    output logic         busy
);

    // Read address shared by both memories
    pixel_addr_t pixel_addr;
    pixel_t hysteresis_data;
    pixel_t mask_data;

    // Selector read path into the counters
    rho_idx_t read_rho;
    theta_idx_t read_theta;
    vote_t read_votes;

    logic accum_done;

    // Edge map from the hysteresis stage
    image_bram u_hysteresis_bram (
        .clock       (clock),
        .write_enable(pixel_write.valid),
        .write_addr  (pixel_write.addr),
        .write_data  (pixel_write.hysteresis),
        .read_addr   (pixel_addr),
        .read_data   (hysteresis_data)
    );

    // Region mask, all ones inside the road area
    image_bram u_mask_bram (
        .clock       (clock),
        .write_enable(pixel_write.valid),
        .write_addr  (pixel_write.addr),
        .write_data  (pixel_write.mask),
        .read_addr   (pixel_addr),
        .read_data   (mask_data)
    );

    hough_accumulator u_hough_accumulator (
        .clock          (clock),
        .reset          (reset),
        .start          (start),
        .hysteresis_data(hysteresis_data),
        .mask_data      (mask_data),
        .pixel_addr     (pixel_addr),
        .read_rho       (read_rho),
        .read_theta     (read_theta),
        .read_votes     (read_votes),
        .select_done    (done),
        .accum_done     (accum_done),
        .busy           (busy)
    );

    // The done pulse also releases the accumulator from SELECT
    lane_select u_lane_select (
        .clock     (clock),
        .reset     (reset),
        .accum_done(accum_done),
        .read_rho  (read_rho),
        .read_theta(read_theta),
        .read_votes(read_votes),
        .lanes     (lanes),
        .done      (done)
    );

endmodule

//--- hdl/hough_pkg.sv
// Hough lane package: shared widths, bus structs, FSM states and quantized trig table
`include "hough_settings.svh"

package hough_pkg;

    // Number of pixels in one image
    localparam int PIXEL_COUNT = `IMAGE_WIDTH * `IMAGE_HEIGHT;

    // One 8-bit image or mask sample
    typedef logic [7:0] pixel_t;
    // Linear image address, row times width plus column
    typedef logic [$clog2(PIXEL_COUNT)-1:0] pixel_addr_t;
    // Column and row of a pixel
    typedef logic [$clog2(`IMAGE_WIDTH)-1:0] coord_x_t;
    typedef logic [$clog2(`IMAGE_HEIGHT)-1:0] coord_y_t;
    // Quantized angle index and rho bin after the offset
    typedef logic [$clog2(`THETAS)-1:0] theta_idx_t;
    typedef logic [$clog2(`RHO_RANGE)-1:0] rho_idx_t;
    // One accumulator counter
    typedef logic [15:0] vote_t;
    // Fixed point cos or sin with TRIG_FRAC fraction bits
    typedef logic signed [9:0] trig_t;

    // Loads the same address of both images in one cycle
    typedef struct packed {
        logic valid;
        pixel_addr_t addr;
        pixel_t hysteresis;
        pixel_t mask;
    } pixel_write_t;

    // One detected line in Hough space
    typedef struct packed {
        rho_idx_t rho;
        theta_idx_t theta;
        vote_t votes;
    } lane_t;

    typedef struct packed {
        lane_t left;
        lane_t right;
    } lane_pair_t;

    typedef enum logic [1:0] {IDLE, ACCUMULATE, THETA_LOOP, SELECT} accum_state_t;
    // Selector states are prefixed apart from the accumulator states
    typedef enum logic {SCAN_IDLE, SCAN} select_state_t;

    localparam real PI = 3.14159265358979323846;

    // Rounds half away from zero after scaling by 2 to the TRIG_FRAC
    function automatic trig_t quantize_trig(input real value);
        real scaled;
        scaled = value * real'(1 << `TRIG_FRAC);
        if (scaled >= 0.0) begin
            return trig_t'($rtoi(scaled + 0.5));
        end
        return trig_t'(-$rtoi(0.5 - scaled));
    endfunction

    function automatic trig_t cos_quantized(input theta_idx_t theta);
        return quantize_trig($cos(PI * real'(theta) / real'(`THETAS)));
    endfunction

    function automatic trig_t sin_quantized(input theta_idx_t theta);
        return quantize_trig($sin(PI * real'(theta) / real'(`THETAS)));
    endfunction

endpackage

//--- hdl/hough_settings.svh
// Hough lane settings: image geometry, ROI, angle quantization and rho binning

`ifndef HOUGH_SETTINGS_SVH
`define HOUGH_SETTINGS_SVH

// Image geometry in pixels
// Both the hysteresis image and the mask use this size
`define IMAGE_WIDTH 16
`define IMAGE_HEIGHT 16

// First row that takes part in voting
// Rows above it hold sky and horizon and are never fetched from memory
`define ROI_TOP_Y 8

// Number of quantized line angles
// Angle index i stands for i times 180/THETAS degrees
`define THETAS 8

// Angles voted in parallel per cycle
// It has to divide THETAS so the loop ends exactly on the last angle
`define THETA_UNROLL 2

// Fraction bits of the fixed point cos and sin table
`define TRIG_FRAC 8

// Number of rho bins in the accumulator
// The signed rho of every ROI pixel has to land inside this range after the offset
`define RHO_RANGE 48

// Offset added to the signed rho so that it becomes a bin index
// Negative rho values come from angles past 90 degrees
`define RHO_OFFSET 24

`endif

//--- hdl/image_bram.sv
// Image memory: one write port and a registered read port, block RAM style
`timescale 1ns/1ps

module image_bram
    import hough_pkg::*;
(
    input  logic        clock,
    // Write port, fed by the outside loader
    input  logic        write_enable,
    input  pixel_addr_t write_addr,
    input  pixel_t      write_data,
    // Read port, data follows the address by one cycle
    input  pixel_addr_t read_addr,
    output pixel_t      read_data
);

    // One byte per pixel for the whole frame
    pixel_t memory [PIXEL_COUNT];

    // The write happens on the same edge as the read
    // A read of the address being written returns the old content
    always_ff @(posedge clock) begin
        if (write_enable) begin
            memory[write_addr] <= write_data;
        end
    end

    // Output register of the memory
    // This is what makes the accumulator present addresses a cycle early
    always_ff @(posedge clock) begin
        read_data <= memory[read_addr];
    end

endmodule

//--- hdl/lane_select.sv
// Lane selector: finds the strongest line in each half of the angle range
`timescale 1ns/1ps
`include "hough_settings.svh"

module lane_select
    import hough_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  logic       accum_done,
    // Indexed read into the accumulator counters
    output rho_idx_t   read_rho,
    output theta_idx_t read_theta,
    input  vote_t      read_votes,
    output lane_pair_t lanes,
    output logic       done
);

    localparam rho_idx_t LAST_RHO = rho_idx_t'(`RHO_RANGE - 1);
    localparam theta_idx_t LAST_THETA = theta_idx_t'(`THETAS - 1);
    // First angle that belongs to the right lane
    localparam theta_idx_t RIGHT_THETA = theta_idx_t'(`THETAS / 2);

    select_state_t state;

    // Entry being read, theta outer and rho inner
    rho_idx_t scan_rho;
    theta_idx_t scan_theta;

    logic scan_end;
    logic left_half;
    // High in the cycle after the last entry was compared
    logic finish;

    lane_t candidate;
    lane_t best_left;
    lane_t best_right;

    assign read_rho = scan_rho;
    assign read_theta = scan_theta;

    assign scan_end = (scan_rho == LAST_RHO) && (scan_theta == LAST_THETA);
    assign left_half = (scan_theta < RIGHT_THETA);
    assign candidate = '{rho: scan_rho, theta: scan_theta, votes: read_votes};

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= SCAN_IDLE;
            scan_rho <= '0;
            scan_theta <= '0;
            finish <= 1'b0;
            done <= 1'b0;
            lanes <= '0;
        end else begin
            finish <= (state == SCAN) && scan_end;
            done <= finish;
            // The last comparison is already in the best lanes here
            if (finish) begin
                lanes <= '{left: best_left, right: best_right};
            end

            case (state)
                SCAN_IDLE: begin
                    if (accum_done) begin
                        state <= SCAN;
                        scan_rho <= '0;
                        scan_theta <= '0;
                    end
                end

                SCAN: begin
                    if (scan_end) begin
                        state <= SCAN_IDLE;
                    end else if (scan_rho == LAST_RHO) begin
                        scan_rho <= '0;
                        scan_theta <= scan_theta + 1'b1;
                    end else begin
                        scan_rho <= scan_rho + 1'b1;
                    end
                end

                default: begin
                    state <= SCAN_IDLE;
                end
            endcase
        end
    end

    // Running maxima, seeded with the first entry of each half at zero votes
    // Only a strictly larger count replaces the best, so the earliest entry wins ties
    always_ff @(posedge clock) begin
        if ((state == SCAN_IDLE) && accum_done) begin
            best_left <= '{rho: '0, theta: '0, votes: '0};
            best_right <= '{rho: '0, theta: RIGHT_THETA, votes: '0};
        end else if (state == SCAN) begin
            if (left_half && (read_votes > best_left.votes)) begin
                best_left <= candidate;
            end
            if (!left_half && (read_votes > best_right.votes)) begin
                best_right <= candidate;
            end
        end
    end

endmodule

//--- list.f
+incdir+hdl
hdl/hough_pkg.sv
hdl/image_bram.sv
hdl/hough_accumulator.sv
hdl/lane_select.sv
hdl/hough_lane_top.sv
verification/hough_tb.sv

//--- verification/hough_tb.sv
// Hough lane testbench: loads test images, runs the DUT and checks the lanes against a vote model
`timescale 1ns/1ps
`include "hough_settings.svh"

module hough_tb
    import hough_pkg::*;
;

    typedef enum int {PAT_EMPTY, PAT_MASKED_LINE, PAT_ABOVE_ROI, PAT_LEFT_DIAG,
                      PAT_RIGHT_DIAG, PAT_RANDOM} pattern_kind_t;

    localparam int CASE_COUNT = 7;
    localparam int ROI_PIXELS = `IMAGE_WIDTH * (`IMAGE_HEIGHT - `ROI_TOP_Y);
    // Load, worst case voting, selector scan and some slack for each case
    localparam int CASE_CYCLES = PIXEL_COUNT + ROI_PIXELS * (1 + `THETAS / `THETA_UNROLL)
                                 + `RHO_RANGE * `THETAS + 64;
    localparam int TIMEOUT_LIMIT = CASE_COUNT * CASE_CYCLES;
    // Zero votes everywhere leaves each lane on the first entry of its half
    localparam lane_pair_t EMPTY_LANES = '{
        left:  '{rho: '0, theta: '0, votes: '0},
        right: '{rho: '0, theta: theta_idx_t'(`THETAS / 2), votes: '0}
    };

    // Case table: image pattern, name, and whether the result must be the empty one
    pattern_kind_t case_kind [CASE_COUNT] = '{PAT_EMPTY, PAT_MASKED_LINE, PAT_ABOVE_ROI,
        PAT_LEFT_DIAG, PAT_RIGHT_DIAG, PAT_RANDOM, PAT_RANDOM};
    string case_name [CASE_COUNT] = '{"empty image", "line outside the mask",
        "line above the ROI", "left diagonal", "right diagonal", "random image one",
        "random image two"};
    logic case_empty [CASE_COUNT] = '{1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0};

    logic clock = 1'b0;
    logic reset;
    logic start;
    pixel_write_t pixel_write;
    lane_pair_t lanes;
    logic done;
    logic busy;

    // Images as they are loaded into the two memories
    pixel_t hyst_image [PIXEL_COUNT];
    pixel_t mask_image [PIXEL_COUNT];
    integer seed = 32'h46a4_c345;
    int cycle_count = 0;
    int done_count = 0;

    hough_lane_top u_hough_lane_top (
        .clock      (clock),
        .reset      (reset),
        .start      (start),
        .pixel_write(pixel_write),
        .lanes      (lanes),
        .done       (done),
        .busy       (busy)
    );

    always #2 clock = ~clock;

    // Outputs are sampled on the falling edge, away from the DUT updates
    always @(negedge clock) begin
        if (done === 1'b1) begin
            done_count++;
        end
    end

    task automatic stop_on_failure();
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at the first failing check");
    endtask

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_LIMIT) begin
            $display("timeout: done never came within %0d cycles", TIMEOUT_LIMIT);
            stop_on_failure();
        end
    end

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] received);
        assert (received === expected) else begin
            $display("error %s expected 0x%0h received 0x%0h", name, expected, received);
            stop_on_failure();
        end
    endtask

    task automatic build_images(input pattern_kind_t kind);
        int a;
        integer r;
        for (int y = 0; y < `IMAGE_HEIGHT; y++) begin
            for (int x = 0; x < `IMAGE_WIDTH; x++) begin
                a = y * `IMAGE_WIDTH + x;
                hyst_image[a] = 8'h00;
                mask_image[a] = 8'hff;
                case (kind)
                    // Edges on a diagonal, but the mask is cleared under them
                    PAT_MASKED_LINE: begin
                        if (x == y) begin
                            hyst_image[a] = 8'hff;
                            mask_image[a] = 8'h00;
                        end
                    end
                    // Both diagonals drawn only in the rows that are never scanned
                    PAT_ABOVE_ROI: begin
                        if ((y < `ROI_TOP_Y) && ((x == y) || (x + y == `IMAGE_WIDTH - 1))) begin
                            hyst_image[a] = 8'hff;
                        end
                    end
                    PAT_LEFT_DIAG: begin
                        if (x + y == `IMAGE_WIDTH - 1) begin
                            hyst_image[a] = 8'hff;
                        end
                    end
                    PAT_RIGHT_DIAG: begin
                        if (x == y) begin
                            hyst_image[a] = 8'h80;
                        end
                    end
                    // Sparse edges of any nonzero value, some under a partial mask
                    PAT_RANDOM: begin
                        r = $random(seed);
                        hyst_image[a] = (r[1:0] == 2'b00) ? (r[15:8] | 8'h01) : 8'h00;
                        mask_image[a] = (r[20:18] == 3'b000) ? 8'h7f : 8'hff;
                    end
                    default: begin
                    end
                endcase
            end
        end
    endtask

    // Edge pixels inside the ROI and the mask, each of which runs the angle loop
    function automatic int count_voting_pixels();
        int count;
        int a;
        count = 0;
        for (int y = `ROI_TOP_Y; y < `IMAGE_HEIGHT; y++) begin
            for (int x = 0; x < `IMAGE_WIDTH; x++) begin
                a = y * `IMAGE_WIDTH + x;
                if ((hyst_image[a] != 8'h00) && (mask_image[a] == 8'hff)) begin
                    count++;
                end
            end
        end
        return count;
    endfunction

    // Votes from the ROI, edge and mask rules, then the half split with first-wins ties
    function automatic lane_pair_t model_lanes();
        int votes [`RHO_RANGE][`THETAS];
        int a;
        int dot;
        int rho;
        lane_pair_t result;
        for (int r = 0; r < `RHO_RANGE; r++) begin
            for (int t = 0; t < `THETAS; t++) begin
                votes[r][t] = 0;
            end
        end
        for (int y = `ROI_TOP_Y; y < `IMAGE_HEIGHT; y++) begin
            for (int x = 0; x < `IMAGE_WIDTH; x++) begin
                a = y * `IMAGE_WIDTH + x;
                if ((hyst_image[a] != 8'h00) && (mask_image[a] == 8'hff)) begin
                    for (int t = 0; t < `THETAS; t++) begin
                        dot = x * int'(cos_quantized(theta_idx_t'(t)))
                              + y * int'(sin_quantized(theta_idx_t'(t)));
                        // Shifting a signed int floors toward minus infinity
                        rho = (dot >>> `TRIG_FRAC) + `RHO_OFFSET;
                        if ((rho >= 0) && (rho < `RHO_RANGE)) begin
                            votes[rho][t]++;
                        end
                    end
                end
            end
        end
        result = EMPTY_LANES;
        for (int t = 0; t < `THETAS; t++) begin
            for (int r = 0; r < `RHO_RANGE; r++) begin
                if ((t < `THETAS / 2) && (votes[r][t] > int'(result.left.votes))) begin
                    result.left = '{rho: rho_idx_t'(r), theta: theta_idx_t'(t),
                                    votes: vote_t'(votes[r][t])};
                end
                if ((t >= `THETAS / 2) && (votes[r][t] > int'(result.right.votes))) begin
                    result.right = '{rho: rho_idx_t'(r), theta: theta_idx_t'(t),
                                     votes: vote_t'(votes[r][t])};
                end
            end
        end
        return result;
    endfunction

    // One pixel of both images per cycle, then the write port goes quiet
    task automatic load_images();
        for (int a = 0; a < PIXEL_COUNT; a++) begin
            @(posedge clock);
            pixel_write <= '{valid: 1'b1, addr: pixel_addr_t'(a),
                             hysteresis: hyst_image[a], mask: mask_image[a]};
        end
        @(posedge clock);
        pixel_write <= '0;
    endtask

    task automatic pulse_start();
        @(posedge clock);
        start <= 1'b1;
        @(posedge clock);
        start <= 1'b0;
    endtask

    task automatic wait_for_done();
        do begin
            @(negedge clock);
        end while (done !== 1'b1);
    endtask

    task automatic run_case(input int index);
        lane_pair_t expected;
        int expected_latency;
        int start_cycle;
        $display("case %0d: %s", index, case_name[index]);
        build_images(case_kind[index]);
        expected = case_empty[index] ? EMPTY_LANES : model_lanes();
        // Scan of the ROI, angle loop of every voting pixel, selector scan and 3 fixed cycles
        expected_latency = ROI_PIXELS + count_voting_pixels() * (`THETAS / `THETA_UNROLL)
                           + `RHO_RANGE * `THETAS + 3;
        load_images();
        pulse_start();
        @(negedge clock);
        // The first start was high in the cycle before this sample point
        start_cycle = cycle_count - 1;
        check_value("busy", 64'd1, busy);
        // A start during the run has to be ignored, a restart would delay done
        pulse_start();
        wait_for_done();
        check_value("latency", expected_latency, cycle_count - start_cycle);
        check_value("lanes.left.rho", expected.left.rho, lanes.left.rho);
        check_value("lanes.left.theta", expected.left.theta, lanes.left.theta);
        check_value("lanes.left.votes", expected.left.votes, lanes.left.votes);
        check_value("lanes.right.rho", expected.right.rho, lanes.right.rho);
        check_value("lanes.right.theta", expected.right.theta, lanes.right.theta);
        check_value("lanes.right.votes", expected.right.votes, lanes.right.votes);
        // Done is a single pulse and busy drops one cycle later
        @(negedge clock);
        check_value("done", 64'd0, done);
        check_value("busy", 64'd0, busy);
        repeat (4) @(negedge clock);
        check_value("done_count", index + 1, done_count);
        check_value("lanes", expected, lanes);
    endtask

    initial begin
        reset = 1'b1;
        start = 1'b0;
        pixel_write = '0;
        repeat (16) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        check_value("done", 64'd0, done);
        check_value("busy", 64'd0, busy);
        check_value("lanes", 64'd0, lanes);
        for (int i = 0; i < CASE_COUNT; i++) begin
            run_case(i);
        end
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule
